// File: Makefile
# Verilator build and run of the data cache testbench
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= Test failures found

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@rm -f $(LOG)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/cache_bank.sv
// one bank of the direct-mapped cache, one word per line
// looks up its dispatched request while not held; while held it reads
// the line at the fill index so the whole victim block can be written
// back, and takes the new block word on the fill strobe
module cache_bank
    import dcache_geom_pkg::*;
    import dcache_xfer_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  bank_req_t          i_req,
    input  logic               i_hold,
    input  logic               i_fill,
    input  logic [INDEX_W-1:0] i_fill_index,
    input  logic [TAG_W-1:0]   i_fill_tag,
    input  word_t              i_fill_data,
    output bank_rsp_t          o_rsp,
    output word_t              o_victim_data
);

    logic [TAG_W-1:0] tag_mem   [LINES_PER_BANK];
    logic             valid_mem [LINES_PER_BANK];
    logic             dirty_mem [LINES_PER_BANK];
    word_t            data_mem  [LINES_PER_BANK];

    logic [INDEX_W-1:0] look_idx;
    logic               tag_match;
    logic               wr_hit;

    // miss controller owns the index while it holds the banks
    assign look_idx  = i_hold ? i_fill_index : i_req.addr.index;
    assign tag_match = valid_mem[look_idx] && (tag_mem[look_idx] == i_req.addr.tag);

    assign o_rsp.hit          = i_req.valid && !i_hold && tag_match;
    assign o_rsp.rdata        = data_mem[look_idx];
    assign o_rsp.victim_dirty = dirty_mem[look_idx];
    assign o_rsp.victim_tag   = tag_mem[look_idx];
    assign o_victim_data      = data_mem[look_idx];

    assign wr_hit = o_rsp.hit && i_req.write;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < LINES_PER_BANK; i++) begin
                tag_mem[i]   <= '0;
                valid_mem[i] <= 1'b0;
                dirty_mem[i] <= 1'b0;
                data_mem[i]  <= '0;
            end
        end else if (i_fill) begin
            // new block arrives clean
            tag_mem[i_fill_index]   <= i_fill_tag;
            valid_mem[i_fill_index] <= 1'b1;
            dirty_mem[i_fill_index] <= 1'b0;
            data_mem[i_fill_index]  <= i_fill_data;
        end else if (wr_hit) begin
            data_mem[look_idx]  <= i_req.wdata;
            dirty_mem[look_idx] <= 1'b1; // written back on eviction
        end
    end

endmodule

// File: design/dcache_geom_pkg.sv
// geometry of the four-bank data cache
// address split, sizes and the block mask shared by dispatch, banks
// and the miss controller; import with a wildcard where needed
package dcache_geom_pkg;

    localparam int NUM_THREADS    = 4;
    localparam int NUM_BANKS      = 4;
    localparam int LINES_PER_BANK = 16;

    localparam int WORD_W   = 32;
    localparam int TAG_W    = 24;
    localparam int INDEX_W  = 4;
    localparam int BANK_W   = 2;
    localparam int THREAD_W = 2;

    // a block is one word per bank, 16 bytes
    localparam logic [WORD_W-1:0] BLOCK_MASK = 32'hFFFF_FFF0;

    typedef logic [WORD_W-1:0] word_t;

    // byte address as seen by the cache
    typedef struct packed {
        logic [TAG_W-1:0]   tag;      // [31:8]
        logic [INDEX_W-1:0] index;    // [7:4]
        logic [BANK_W-1:0]  bank;     // [3:2]
        logic [1:0]         byte_off; // ignored, word access only
    } addr_fields_t;

endpackage

// File: design/dcache_top.sv
// four-bank data cache for a batch of four threads
// threads hold their batch while o_p_delay is high; memory gets a
// one-cycle o_m_valid strobe per miss and answers with i_m_ready
module dcache_top
    import dcache_geom_pkg::*;
    import dcache_xfer_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  thread_mask_t i_p_valid,
    input  word_t        i_p_addr [NUM_THREADS],
    input  word_t        i_p_wdata [NUM_THREADS],
    input  logic         i_p_write,
    output word_t        o_p_rdata [NUM_THREADS],
    output logic         o_p_delay,
    output logic         o_m_valid,
    output logic         o_m_write,
    output word_t        o_m_evict_addr,
    output word_t        o_m_read_addr,
    output word_t        o_m_wdata [NUM_BANKS],
    input  logic         i_m_ready,
    input  word_t        i_m_rdata [NUM_BANKS]
);

    thread_mask_t       active;
    bank_req_t          bank_req [NUM_BANKS];
    bank_rsp_t          bank_rsp [NUM_BANKS];
    logic               hold;
    logic               fill;
    logic [INDEX_W-1:0] fill_index;
    logic [TAG_W-1:0]   fill_tag;

    thread_bank_dispatch u_dispatch (
        .i_active   (active),
        .i_addr     (i_p_addr),
        .i_wdata    (i_p_wdata),
        .i_write    (i_p_write),
        .o_bank_req (bank_req)
    );

    // word b of every block lives in bank b
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        cache_bank u_bank (
            .clk           (clk),
            .rst           (rst),
            .i_req         (bank_req[b]),
            .i_hold        (hold),
            .i_fill        (fill),
            .i_fill_index  (fill_index),
            .i_fill_tag    (fill_tag),
            .i_fill_data   (i_m_rdata[b]),
            .o_rsp         (bank_rsp[b]),
            .o_victim_data (o_m_wdata[b])
        );
    end

    miss_controller u_miss_ctrl (
        .clk            (clk),
        .rst            (rst),
        .i_bank_req     (bank_req),
        .i_bank_rsp     (bank_rsp),
        .o_hold         (hold),
        .o_fill         (fill),
        .o_fill_index   (fill_index),
        .o_fill_tag     (fill_tag),
        .o_m_valid      (o_m_valid),
        .o_m_write      (o_m_write),
        .o_m_evict_addr (o_m_evict_addr),
        .o_m_read_addr  (o_m_read_addr),
        .i_m_ready      (i_m_ready)
    );

    response_merge u_merge (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (i_p_valid),
        .i_hold     (hold),
        .i_bank_req (bank_req),
        .i_bank_rsp (bank_rsp),
        .o_active   (active),
        .o_rdata    (o_p_rdata),
        .o_delay    (o_p_delay)
    );

endmodule

// File: design/dcache_xfer_pkg.sv
// transfer records passed between the cache blocks
// thread masks, per-bank request and result, the latched miss
// and the miss FSM state encoding
package dcache_xfer_pkg;

    import dcache_geom_pkg::*;

    typedef logic [NUM_THREADS-1:0] thread_mask_t;

    // request picked for one bank this cycle
    typedef struct packed {
        logic                valid;
        logic [THREAD_W-1:0] thread;
        addr_fields_t        addr;
        word_t               wdata;
        logic                write;
    } bank_req_t;

    // lookup result of one bank
    typedef struct packed {
        logic             hit;
        word_t            rdata;
        logic             victim_dirty;
        logic [TAG_W-1:0] victim_tag;
    } bank_rsp_t;

    // miss waiting for memory, both addresses block aligned
    typedef struct packed {
        word_t miss_addr;
        word_t victim_addr;
        logic  writeback;
    } miss_info_t;

    typedef enum logic [1:0] {
        IDLE,
        SEND_MEM_REQ,
        RECV_MEM_RSP
    } mc_state_t;

endpackage

// File: design/miss_controller.sv
// miss handling for the bank array, one miss at a time
// latches the lowest missing bank's block, strobes memory once,
// waits for the ready pulse and fills all banks on that cycle
// hold stays high whenever the FSM is away from IDLE
module miss_controller
    import dcache_geom_pkg::*;
    import dcache_xfer_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  bank_req_t          i_bank_req [NUM_BANKS],
    input  bank_rsp_t          i_bank_rsp [NUM_BANKS],
    output logic               o_hold,
    output logic               o_fill,
    output logic [INDEX_W-1:0] o_fill_index,
    output logic [TAG_W-1:0]   o_fill_tag,
    output logic               o_m_valid,
    output logic               o_m_write,
    output word_t              o_m_evict_addr,
    output word_t              o_m_read_addr,
    input  logic               i_m_ready
);

    mc_state_t state_q;
    mc_state_t state_d;

    logic [NUM_BANKS-1:0] miss_vec;
    logic [NUM_BANKS-1:0] dirty_vec;
    miss_info_t           cand [NUM_BANKS];
    miss_info_t           miss_sel;
    logic                 miss_found;
    miss_info_t           miss_q;
    addr_fields_t         miss_f;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_cand
        assign miss_vec[b]  = i_bank_req[b].valid && !i_bank_rsp[b].hit;
        assign dirty_vec[b] = i_bank_rsp[b].victim_dirty;

        assign cand[b].miss_addr   = word_t'(i_bank_req[b].addr) & BLOCK_MASK;
        assign cand[b].victim_addr = {i_bank_rsp[b].victim_tag, i_bank_req[b].addr.index,
                                      i_bank_req[b].addr.bank, i_bank_req[b].addr.byte_off}
                                     & BLOCK_MASK;
        assign cand[b].writeback   = i_bank_rsp[b].victim_dirty;
    end

    priority_select #(
        .N         (NUM_BANKS),
        .payload_t (miss_info_t)
    ) u_pick_miss (
        .i_valid   (miss_vec),
        .i_payload (cand),
        .o_found   (miss_found),
        .o_index   (),
        .o_onehot  (),
        .o_payload (miss_sel)
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:         if (miss_found) state_d = SEND_MEM_REQ;
            SEND_MEM_REQ: state_d = RECV_MEM_RSP;
            RECV_MEM_RSP: if (i_m_ready) state_d = IDLE;
            default:      state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // only captured from IDLE, later misses wait their turn
    always_ff @(posedge clk) begin
        if (state_q == IDLE && miss_found) begin
            miss_q <= miss_sel;
        end
    end

    assign miss_f       = miss_q.miss_addr;
    assign o_fill_index = miss_f.index;
    assign o_fill_tag   = miss_f.tag;

    assign o_hold    = (state_q != IDLE);
    assign o_fill    = (state_q == RECV_MEM_RSP) && i_m_ready;
    assign o_m_valid = (state_q == SEND_MEM_REQ);
    // banks read the victim index while held, so any dirty word counts
    assign o_m_write = (state_q == SEND_MEM_REQ) && (miss_q.writeback || (|dirty_vec));

    assign o_m_evict_addr = miss_q.victim_addr;
    assign o_m_read_addr  = miss_q.miss_addr;

endmodule

// File: design/priority_select.sv
// lowest-index selector over N candidates
// returns whether any candidate is valid, its index, a one-hot mask
// and its payload; payload is zero when nothing is valid
module priority_select #(
    parameter int  N         = 4,
    parameter type payload_t = logic
) (
    input  logic [N-1:0]         i_valid,
    input  payload_t             i_payload [N],
    output logic                 o_found,
    output logic [$clog2(N)-1:0] o_index,
    output logic [N-1:0]         o_onehot,
    output payload_t             o_payload
);

    always_comb begin
        o_found   = 1'b0;
        o_index   = '0;
        o_onehot  = '0;
        o_payload = '0;
        // scan downward so the lowest valid entry is the last one taken
        for (int i = N - 1; i >= 0; i--) begin
            if (i_valid[i]) begin
                o_found     = 1'b1;
                o_index     = i[$clog2(N)-1:0];
                o_onehot    = '0;
                o_onehot[i] = 1'b1;
                o_payload   = i_payload[i];
            end
        end
    end

endmodule

// File: design/response_merge.sv
// collects per-bank results into per-thread state
// tracks which threads of the batch are still pending, registers
// read-hit data per thread and raises delay until the batch is done
module response_merge
    import dcache_geom_pkg::*;
    import dcache_xfer_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  thread_mask_t i_valid,
    input  logic         i_hold,
    input  bank_req_t    i_bank_req [NUM_BANKS],
    input  bank_rsp_t    i_bank_rsp [NUM_BANKS],
    output thread_mask_t o_active,
    output word_t        o_rdata [NUM_THREADS],
    output logic         o_delay
);

    thread_mask_t         pending_q;
    thread_mask_t         served;
    thread_mask_t         pending_d;
    logic [NUM_BANKS-1:0] bank_served;

    // a fresh batch is taken only when nothing is left over
    assign o_active = (pending_q != '0) ? pending_q : i_valid;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        assign bank_served[b] = i_bank_req[b].valid && i_bank_rsp[b].hit && !i_hold;
    end

    always_comb begin
        served = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (bank_served[b]) begin
                served[i_bank_req[b].thread] = 1'b1;
            end
        end
    end

    assign pending_d = o_active & ~served;
    assign o_delay   = (pending_d != '0) || i_hold;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending_q <= '0;
            for (int t = 0; t < NUM_THREADS; t++) begin
                o_rdata[t] <= '0;
            end
        end else begin
            pending_q <= pending_d;
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (bank_served[b] && !i_bank_req[b].write) begin
                    o_rdata[i_bank_req[b].thread] <= i_bank_rsp[b].rdata;
                end
            end
        end
    end

endmodule

// File: design/thread_bank_dispatch.sv
// thread to bank dispatch
// every active thread bids for the bank its address selects, and each
// bank takes the lowest-numbered bidder; losers wait for a later cycle
module thread_bank_dispatch
    import dcache_geom_pkg::*;
    import dcache_xfer_pkg::*;
(
    input  thread_mask_t i_active,
    input  word_t        i_addr [NUM_THREADS],
    input  word_t        i_wdata [NUM_THREADS],
    input  logic         i_write,
    output bank_req_t    o_bank_req [NUM_BANKS]
);

    bank_req_t    cand [NUM_THREADS];    // one candidate per thread
    thread_mask_t bank_match [NUM_BANKS];

    // candidate request of each thread
    for (genvar t = 0; t < NUM_THREADS; t++) begin : g_cand
        addr_fields_t fields;

        assign fields = i_addr[t];

        assign cand[t].valid  = i_active[t];
        assign cand[t].thread = THREAD_W'(t);
        assign cand[t].addr   = fields;
        assign cand[t].wdata  = i_wdata[t];
        assign cand[t].write  = i_write; // whole batch reads or writes
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        // active threads whose bank field points here
        always_comb begin
            bank_match[b] = '0;
            for (int t = 0; t < NUM_THREADS; t++) begin
                if (i_active[t] && cand[t].addr.bank == BANK_W'(b)) begin
                    bank_match[b][t] = 1'b1;
                end
            end
        end

        // payload comes back zeroed, so valid drops when no thread matched
        priority_select #(
            .N         (NUM_THREADS),
            .payload_t (bank_req_t)
        ) u_pick_thread (
            .i_valid   (bank_match[b]),
            .i_payload (cand),
            .o_found   (),
            .o_index   (),
            .o_onehot  (),
            .o_payload (o_bank_req[b])
        );
    end

endmodule

// File: tb.f
design/dcache_geom_pkg.sv
design/dcache_xfer_pkg.sv
design/priority_select.sv
design/thread_bank_dispatch.sv
design/cache_bank.sv
design/miss_controller.sv
design/response_merge.sv
design/dcache_top.sv
test/tb_dcache.sv

// File: test/tb_dcache.sv
// testbench for the four-bank data cache
// runs random read and write batches against a flat golden memory,
// answers misses from a memory model with random latency and checks
// read data, write-backs, the memory strobe and the all-hit fast path
module tb_dcache
    import dcache_geom_pkg::*;
    import dcache_xfer_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_ROUNDS   = 300;
    localparam int ROUND_CYCLES = 40;  // budget per round, misses included
    localparam int MAX_CYCLES   = NUM_ROUNDS * ROUND_CYCLES + RESET_CYCLES;
    localparam int HIT_TEST_GAP = 25;  // rounds between all-hit batches

    // small tag pool so lines conflict and dirty blocks get evicted
    localparam logic [TAG_W-1:0] TAG_POOL [3] = '{24'h00_0012, 24'h00_0345, 24'h00_6789};

    // one thread's slot in a batch
    typedef struct packed {
        word_t addr;
        word_t wdata;
    } access_t;

    logic         clk;
    logic         rst;
    thread_mask_t i_p_valid;
    word_t        i_p_addr [NUM_THREADS];
    word_t        i_p_wdata [NUM_THREADS];
    logic         i_p_write;
    word_t        o_p_rdata [NUM_THREADS];
    logic         o_p_delay;
    logic         o_m_valid;
    logic         o_m_write;
    word_t        o_m_evict_addr;
    word_t        o_m_read_addr;
    word_t        o_m_wdata [NUM_BANKS];
    logic         i_m_ready;
    word_t        i_m_rdata [NUM_BANKS];

    access_t batch [NUM_THREADS];
    word_t   gold [word_t];  // flat reference memory, word addressed by byte address
    word_t   mem [word_t];   // backing store behind the cache
    int      error_count = 0;
    int      check_count = 0;
    int      mem_req_count = 0;
    int      cycle_count = 0;

    dcache_top DUT (
        .clk            (clk),
        .rst            (rst),
        .i_p_valid      (i_p_valid),
        .i_p_addr       (i_p_addr),
        .i_p_wdata      (i_p_wdata),
        .i_p_write      (i_p_write),
        .o_p_rdata      (o_p_rdata),
        .o_p_delay      (o_p_delay),
        .o_m_valid      (o_m_valid),
        .o_m_write      (o_m_write),
        .o_m_evict_addr (o_m_evict_addr),
        .o_m_read_addr  (o_m_read_addr),
        .o_m_wdata      (o_m_wdata),
        .i_m_ready      (i_m_ready),
        .i_m_rdata      (i_m_rdata)
    );

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR: %s actual=%h expected=%h (time %0t)", name, actual, expected, $time);
        end
    endtask

    task automatic report_problem(input string what);
        error_count++;
        $display("ERROR: %s (time %0t)", what, $time);
    endtask

    function automatic word_t gold_word(input word_t addr);
        word_t w;
        w = gold.exists(addr) ? gold[addr] : '0; // untouched words read as zero
        return w;
    endfunction

    function automatic word_t mem_word(input word_t addr);
        word_t w;
        w = mem.exists(addr) ? mem[addr] : '0;
        return w;
    endfunction

    task automatic check_reset_state();
        check_value("o_m_valid", 32'(o_m_valid), '0);
        check_value("o_m_write", 32'(o_m_write), '0);
        check_value("o_p_delay", 32'(o_p_delay), '0);
        for (int t = 0; t < NUM_THREADS; t++) begin
            check_value($sformatf("o_p_rdata[%0d]", t), o_p_rdata[t], '0);
        end
    endtask

    // a write batch keeps one tag per line index, so it never evicts
    // a block that it is still writing
    task automatic make_random_batch(input logic write);
        logic [TAG_W-1:0]   line_tag [1 << INDEX_W];
        logic [INDEX_W-1:0] idx;
        logic [BANK_W-1:0]  bank;
        logic [TAG_W-1:0]   tag;

        for (int i = 0; i < (1 << INDEX_W); i++) begin
            line_tag[i] = TAG_POOL[$urandom_range(0, 2)];
        end
        for (int t = 0; t < NUM_THREADS; t++) begin
            idx  = INDEX_W'($urandom_range(0, 3));
            bank = BANK_W'($urandom_range(0, 3));
            tag  = write ? line_tag[idx] : TAG_POOL[$urandom_range(0, 2)];
            batch[t].addr  = {tag, idx, bank, 2'b00};
            batch[t].wdata = $urandom;
        end
    endtask

    // drives batch[] from a falling edge, samples o_p_delay inside the
    // low clock phase until it is seen low, then checks read data at
    // the falling edge after the closing rising edge
    task automatic run_batch(input thread_mask_t valid, input logic write,
                             output logic first_delay, output int reqs);
        int   start_reqs;
        int   cycles;
        logic waiting;

        start_reqs = mem_req_count;
        i_p_valid  = valid;
        i_p_write  = write;
        for (int t = 0; t < NUM_THREADS; t++) begin
            i_p_addr[t]  = batch[t].addr;
            i_p_wdata[t] = batch[t].wdata;
            if (write && valid[t]) begin
                gold[batch[t].addr] = batch[t].wdata; // thread order, higher thread stays
            end
        end
        first_delay = 1'b0;
        cycles      = 0;
        waiting     = 1'b1;
        while (waiting) begin
            #(CLK_PERIOD / 4);
            if (cycles == 0) begin
                first_delay = o_p_delay;
            end
            waiting = o_p_delay;
            cycles++;
            @(negedge clk);
        end
        reqs = mem_req_count - start_reqs;
        if (!write) begin
            for (int t = 0; t < NUM_THREADS; t++) begin
                if (valid[t]) begin
                    check_value($sformatf("o_p_rdata[%0d]", t), o_p_rdata[t],
                                gold_word(batch[t].addr));
                end
            end
        end
    endtask

    // warm up one block, then touch each bank once inside it
    task automatic hit_block_test();
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] idx;
        logic [BANK_W-1:0]  rot;
        logic               write;
        logic               first_delay;
        int                 reqs;

        tag   = TAG_POOL[$urandom_range(0, 2)];
        idx   = INDEX_W'($urandom_range(0, 3));
        rot   = BANK_W'($urandom_range(0, 3));
        write = 1'($urandom_range(0, 1));
        for (int t = 0; t < NUM_THREADS; t++) begin
            batch[t].addr  = {tag, idx, rot + BANK_W'(t), 2'b00};
            batch[t].wdata = $urandom;
        end
        run_batch('1, 1'b0, first_delay, reqs);
        run_batch('1, write, first_delay, reqs);
        check_value("o_p_delay in first cycle of all-hit batch", 32'(first_delay), '0);
        check_value("memory requests in all-hit batch", 32'(reqs), '0);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
        $display("Test failures found");
        $finish;
    end

    // memory model, takes the strobe and answers after 1 to 4 cycles
    initial begin
        word_t read_addr;
        int    wait_left;
        logic  open_req;
        logic  valid_seen;

        i_m_ready = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            i_m_rdata[b] = '0;
        end
        read_addr  = '0;
        wait_left  = 0;
        open_req   = 1'b0;
        valid_seen = 1'b0;
        forever begin
            @(negedge clk);
            i_m_ready = 1'b0;
            if (o_m_valid) begin
                if (valid_seen) begin
                    report_problem("o_m_valid stayed high for more than one cycle");
                end
                if (open_req) begin
                    report_problem("memory request issued while the previous one was open");
                end
                check_value("o_m_evict_addr[3:0]", o_m_evict_addr & 32'hF, '0);
                check_value("o_m_read_addr[3:0]", o_m_read_addr & 32'hF, '0);
                if (o_m_write) begin
                    for (int b = 0; b < NUM_BANKS; b++) begin
                        check_value($sformatf("o_m_wdata[%0d]", b), o_m_wdata[b],
                                    gold_word(o_m_evict_addr + word_t'(4 * b)));
                        mem[o_m_evict_addr + word_t'(4 * b)] = o_m_wdata[b];
                    end
                end
                read_addr = o_m_read_addr;
                wait_left = $urandom_range(1, 4);
                open_req  = 1'b1;
                mem_req_count++;
            end else if (open_req) begin
                wait_left--;
                if (wait_left == 0) begin
                    i_m_ready = 1'b1; // one-cycle pulse with the block
                    for (int b = 0; b < NUM_BANKS; b++) begin
                        i_m_rdata[b] = mem_word(read_addr + word_t'(4 * b));
                    end
                    open_req = 1'b0;
                end
            end
            valid_seen = o_m_valid;
        end
    end

    initial begin
        logic         first_delay;
        int           reqs;
        logic         write;
        thread_mask_t valid;

        void'($urandom(32'h2261));
        rst       = 1'b1;
        i_p_valid = '0;
        i_p_write = 1'b0;
        for (int t = 0; t < NUM_THREADS; t++) begin
            i_p_addr[t]  = '0;
            i_p_wdata[t] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_reset_state();

        for (int r = 0; r < NUM_ROUNDS; r++) begin
            write = 1'($urandom_range(0, 1));
            valid = thread_mask_t'($urandom_range(1, 15));
            make_random_batch(write);
            run_batch(valid, write, first_delay, reqs);
            if (write) begin
                run_batch(valid, 1'b0, first_delay, reqs); // read back the same words
            end
            if (r % HIT_TEST_GAP == HIT_TEST_GAP - 1) begin
                hit_block_test();
            end
        end

        $display("%0d errors in %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
